/* hdl/zx_defs.svh */
`ifndef ZX_DEFS_SVH
`define ZX_DEFS_SVH

// ============================================================
// Z80 bus
// ============================================================
`define ZX_ADDR_W       16          // CPU address, one word
`define ZX_DATA_W       8           // CPU data, one byte

// ============================================================
// External RAM layout
// ============================================================
`define ZX_RAM_ADDR_W   24
`define ZX_BANK_W       14          // Offset inside a 16K bank
`define ZX_PAGE_W       6           // RAM page number, 64 pages of 16K
`define ZX_PAGE_LO_W    3           // Page bits held in 7FFD

// ROM banks sit at 101x_xxxx in the RAM address space
`define ZX_ROM_PREFIX   3'b101
`define ZX_ROM_BANK_W   4

// Enum widths for the package types
`define ZX_MODE_W       3
`define ZX_PORT_W       3

// Profi 1024 decodes its extended port on the full address
`define ZX_PORT_DFFD    16'hDFFD

`endif

/* hdl/zx_pkg.sv */
`include "zx_defs.svh"

package zx_pkg;

	// Memory model, same order as the board menu
	typedef enum logic [`ZX_MODE_W-1:0] {
		mm_std128    = 3'd0,
		mm_pent1024  = 3'd1,
		mm_profi1024 = 3'd2,
		mm_std48     = 3'd3,
		mm_plus3     = 3'd4
	} mem_mode_e;

	// Paging port hit by the current I/O write
	typedef enum logic [`ZX_PORT_W-1:0] {
		pp_none,
		pp_7ffd,    // 128K paging
		pp_1ffd,    // +3 special paging and ROM high bit
		pp_eff7,    // Pentagon 1024 config
		pp_dffd     // Profi 1024 extended page
	} page_port_e;

endpackage

/* hdl/io_cycle_decode.sv */
`include "zx_defs.svh"

module io_cycle_decode (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic [`ZX_ADDR_W-1:0]  addr,
	input  logic                   n_iorq,
	input  logic                   n_wr,
	input  logic                   n_m1,
	input  zx_pkg::mem_mode_e      mem_mode,
	input  logic                   page_lock,
	output logic                   wr_stb,
	output zx_pkg::page_port_e     port_sel
);

	// ============================================================
	// I/O write cycle detect
	// ============================================================
	logic io_wr;
	logic io_wr_d;     // Level seen on the previous clock

	// M1 high keeps interrupt acknowledge out
	assign io_wr = ~n_iorq & ~n_wr & n_m1;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_d <= 1'b0;
		end else begin
			io_wr_d <= io_wr;
		end
	end

	// High only on the first clock of the cycle, quiet in reset
	assign wr_stb = io_wr & ~io_wr_d & ~reset;

	// ============================================================
	// Partial address decode of the paging ports
	// ============================================================
	logic is_plus3;
	logic is_pent;
	logic is_profi;
	logic hit_7ffd;
	logic hit_1ffd;
	logic hit_eff7;
	logic hit_dffd;

	assign is_plus3 = (mem_mode == zx_pkg::mm_plus3);
	assign is_pent  = (mem_mode == zx_pkg::mm_pent1024);
	assign is_profi = (mem_mode == zx_pkg::mm_profi1024);

	// +3 needs a14 high to keep 7FFD apart from 1FFD
	assign hit_7ffd = ~addr[15] & ~addr[1] & (addr[14] | ~is_plus3) & ~page_lock;

	assign hit_1ffd = is_plus3 & ~addr[15] & ~addr[14] & ~addr[13] & addr[12]
		& ~addr[1] & ~page_lock;

	// Pentagon config port ignores the lock
	assign hit_eff7 = is_pent & addr[15] & addr[14] & addr[13] & ~addr[12] & ~addr[3];

	assign hit_dffd = is_profi & (addr == `ZX_PORT_DFFD);

	// 7FFD has priority over 1FFD
	always_comb begin
		if (hit_7ffd) begin
			port_sel = zx_pkg::pp_7ffd;
		end else if (hit_1ffd) begin
			port_sel = zx_pkg::pp_1ffd;
		end else if (hit_eff7) begin
			port_sel = zx_pkg::pp_eff7;
		end else if (hit_dffd) begin
			port_sel = zx_pkg::pp_dffd;
		end else begin
			port_sel = zx_pkg::pp_none;
		end
	end

endmodule

/* hdl/page_regs.sv */
`include "zx_defs.svh"

module page_regs (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  zx_pkg::mem_mode_e      mem_mode_cfg,
	input  logic                   wr_stb,
	input  zx_pkg::page_port_e     port_sel,
	input  logic [`ZX_DATA_W-1:0]  data_out,
	output zx_pkg::mem_mode_e      mem_mode,
	output logic                   page_lock,
	output logic [`ZX_PAGE_W-1:0]  page_ram,
	output logic                   rom_sel48,
	output logic                   plus3_special,
	output logic [2:1]             plus3_reg,
	output logic                   scr_page
);

	localparam int EXT_W = `ZX_PAGE_W - `ZX_PAGE_LO_W;

	// ============================================================
	// Paging registers
	// ============================================================
	logic [5:0]       reg_7ffd;    // Page, screen, ROM, lock
	logic [2:0]       reg_1ffd;    // Special layout and ROM high bit
	logic             eff7_lock;   // EFF7 bit 2, 128K compatible lock on Pentagon
	logic [EXT_W-1:0] page_ext;    // Upper page bits of the 1024K machines

	logic is_pent;

	assign is_pent = (mem_mode == zx_pkg::mm_pent1024);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mem_mode  <= mem_mode_cfg;    // Model only changes under reset
			reg_7ffd  <= '0;
			reg_1ffd  <= '0;
			eff7_lock <= 1'b0;
			page_ext  <= '0;
		end else if (wr_stb) begin
			case (port_sel)
				zx_pkg::pp_7ffd: begin
					reg_7ffd <= data_out[5:0];
					// Pentagon takes bits 5,7,6 as extra page bits
					if (is_pent && !eff7_lock) begin
						page_ext <= {data_out[5], data_out[7:6]};
					end
				end
				zx_pkg::pp_1ffd: begin
					reg_1ffd <= data_out[2:0];
				end
				zx_pkg::pp_eff7: begin
					eff7_lock <= data_out[2];
				end
				zx_pkg::pp_dffd: begin
					page_ext <= data_out[EXT_W-1:0];   // Profi extended page
				end
				default: begin
				end
			endcase
		end
	end

	// ============================================================
	// Derived page fields
	// ============================================================
	always_comb begin
		if (mem_mode == zx_pkg::mm_std48) begin
			page_lock = 1'b1;                          // 48K never pages
		end else if (is_pent) begin
			page_lock = reg_7ffd[5] & eff7_lock;
		end else begin
			page_lock = reg_7ffd[5];
		end
	end

	assign page_ram      = {page_ext, reg_7ffd[`ZX_PAGE_LO_W-1:0]};
	assign scr_page      = reg_7ffd[3];    // Shadow screen in page 7
	assign rom_sel48     = reg_7ffd[4];
	assign plus3_special = reg_1ffd[0];
	assign plus3_reg     = reg_1ffd[2:1];

endmodule

/* hdl/ram_addr_map.sv */
`include "zx_defs.svh"

module ram_addr_map (
	input  logic [`ZX_ADDR_W-1:0]      addr,
	input  logic                       n_mreq,
	input  logic                       n_rd,
	input  logic                       n_wr,
	input  zx_pkg::mem_mode_e          mem_mode,
	input  logic [`ZX_PAGE_W-1:0]      page_ram,
	input  logic                       rom_sel48,
	input  logic                       plus3_special,
	input  logic [2:1]                 plus3_reg,
	output logic [`ZX_RAM_ADDR_W-1:0]  ram_addr,
	output logic                       ram_rd,
	output logic                       ram_we
);

	localparam int PAGE_PAD_W = `ZX_RAM_ADDR_W - `ZX_PAGE_W - `ZX_BANK_W;
	localparam int ROM_PAD_W  = `ZX_RAM_ADDR_W - 3 - `ZX_ROM_BANK_W - `ZX_BANK_W;

	logic [1:0]                 quarter;
	logic [`ZX_BANK_W-1:0]      offset;
	logic                       is_48;
	logic                       is_plus3;
	logic [`ZX_ROM_BANK_W-1:0]  rom_bank;
	logic [`ZX_PAGE_W-1:0]      page;
	logic                       in_rom;

	assign quarter  = addr[15:14];
	assign offset   = addr[`ZX_BANK_W-1:0];
	assign is_48    = (mem_mode == zx_pkg::mm_std48);
	assign is_plus3 = (mem_mode == zx_pkg::mm_plus3);

	// ============================================================
	// ROM bank choice
	// ============================================================
	always_comb begin
		if (is_plus3) begin
			rom_bank = {2'b10, plus3_reg[2], rom_sel48};
		end else begin
			rom_bank = {is_48, 2'b11, is_48 | rom_sel48};    // 48K forces the last bank
		end
	end

	// ============================================================
	// Page of the addressed quarter
	// ============================================================
	always_comb begin
		page   = '0;
		in_rom = 1'b0;
		if (plus3_special) begin
			// All-RAM layouts of the +3
			case (plus3_reg)
				2'd0: page = {4'b0000, quarter};
				2'd1: page = {4'b0001, quarter};
				2'd2: page = (quarter == 2'd3) ? 6'd3 : {4'b0001, quarter};
				default: begin
					if (quarter == 2'd1) begin
						page = 6'd7;
					end else if (quarter == 2'd3) begin
						page = 6'd3;
					end else begin
						page = {4'b0001, quarter};
					end
				end
			endcase
		end else begin
			case (quarter)
				2'd0: in_rom = 1'b1;
				2'd1: page = 6'd5;
				2'd2: page = 6'd2;
				default: page = page_ram;    // Banked quarter at C000
			endcase
		end
	end

	assign ram_addr = in_rom ? {{ROM_PAD_W{1'b0}}, `ZX_ROM_PREFIX, rom_bank, offset}
		: {{PAGE_PAD_W{1'b0}}, page, offset};

	// ============================================================
	// RAM strobes
	// ============================================================
	assign ram_rd = ~n_mreq & ~n_rd;
	assign ram_we = ~n_mreq & ~n_wr & ~in_rom;    // ROM quarter is write protected

endmodule

/* hdl/zx_memory_map.sv */
`include "zx_defs.svh"

module zx_memory_map (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  zx_pkg::mem_mode_e          mem_mode_cfg,
	input  logic [`ZX_ADDR_W-1:0]      addr,
	input  logic [`ZX_DATA_W-1:0]      data_out,
	input  logic                       n_mreq,
	input  logic                       n_iorq,
	input  logic                       n_rd,
	input  logic                       n_wr,
	input  logic                       n_m1,
	output logic [`ZX_RAM_ADDR_W-1:0]  ram_addr,
	output logic                       ram_rd,
	output logic                       ram_we,
	output logic                       scr_page
);

	// ============================================================
	// Internal nets
	// ============================================================
	zx_pkg::mem_mode_e       mem_mode;
	zx_pkg::page_port_e      port_sel;
	logic                    page_lock;
	logic                    wr_stb;
	logic [`ZX_PAGE_W-1:0]   page_ram;
	logic                    rom_sel48;
	logic                    plus3_special;
	logic [2:1]              plus3_reg;

	// Bus watcher, one strobe per I/O write
	io_cycle_decode u_io_cycle_decode (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.addr      (addr),
		.n_iorq    (n_iorq),
		.n_wr      (n_wr),
		.n_m1      (n_m1),
		.mem_mode  (mem_mode),
		.page_lock (page_lock),
		.wr_stb    (wr_stb),
		.port_sel  (port_sel)
	);

	page_regs u_page_regs (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.mem_mode_cfg  (mem_mode_cfg),
		.wr_stb        (wr_stb),
		.port_sel      (port_sel),
		.data_out      (data_out),
		.mem_mode      (mem_mode),
		.page_lock     (page_lock),
		.page_ram      (page_ram),
		.rom_sel48     (rom_sel48),
		.plus3_special (plus3_special),
		.plus3_reg     (plus3_reg),
		.scr_page      (scr_page)
	);

	// Pure decode, follows addr in the same cycle
	ram_addr_map u_ram_addr_map (
		.addr          (addr),
		.n_mreq        (n_mreq),
		.n_rd          (n_rd),
		.n_wr          (n_wr),
		.mem_mode      (mem_mode),
		.page_ram      (page_ram),
		.rom_sel48     (rom_sel48),
		.plus3_special (plus3_special),
		.plus3_reg     (plus3_reg),
		.ram_addr      (ram_addr),
		.ram_rd        (ram_rd),
		.ram_we        (ram_we)
	);

endmodule

/* dv/clk_gen.sv */
module clk_gen (
	input  logic restart,     // Pulse to start a fresh reset
	output logic clk_sys,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RESET_CYCLES = 16;

	int unsigned hold_cnt = RESET_CYCLES;

	// 4 ns period
	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		if (restart) begin
			hold_cnt <= RESET_CYCLES;
		end else if (hold_cnt != 0) begin
			hold_cnt <= hold_cnt - 1;
		end
	end

	assign reset = (hold_cnt != 0);

endmodule

/* dv/zx_memory_map_asserts.sv */
`include "zx_defs.svh"

module zx_memory_map_asserts (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   wr_stb,
	input  logic [`ZX_ADDR_W-1:0]  addr,
	input  logic                   ram_we,
	input  logic                   plus3_special
);

	timeunit 1ns;
	timeprecision 100ps;

	int unsigned assert_fails = 0;

	// ============================================================
	// I/O write strobe
	// ============================================================
	property p_stb_one_cycle;
		@(posedge clk_sys) disable iff (reset) wr_stb |=> !wr_stb;
	endproperty

	property p_stb_quiet_in_reset;
		@(posedge clk_sys) reset |-> !wr_stb;
	endproperty

	a_stb_one_cycle: assert property (p_stb_one_cycle)
		else begin
			assert_fails++;
			$error("wr_stb stayed high for two cycles");
		end

	a_stb_quiet_in_reset: assert property (p_stb_quiet_in_reset)
		else begin
			assert_fails++;
			$error("wr_stb high while reset is active");
		end

	// ROM quarter is read only in normal layout
	property p_no_rom_write;
		@(posedge clk_sys) disable iff (reset)
			(addr[15:14] == 2'b00 && !plus3_special) |-> !ram_we;
	endproperty

	a_no_rom_write: assert property (p_no_rom_write)
		else begin
			assert_fails++;
			$error("ram_we high in quarter 0 with normal layout");
		end

endmodule

bind zx_memory_map zx_memory_map_asserts u_asserts (
	.clk_sys       (clk_sys),
	.reset         (reset),
	.wr_stb        (wr_stb),
	.addr          (addr),
	.ram_we        (ram_we),
	.plus3_special (plus3_special)
);

/* dv/zx_memory_map_tb.sv */
`include "zx_defs.svh"

module zx_memory_map_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam zx_pkg::mem_mode_e m128   = zx_pkg::mm_std128;
	localparam zx_pkg::mem_mode_e m48    = zx_pkg::mm_std48;
	localparam zx_pkg::mem_mode_e mpent  = zx_pkg::mm_pent1024;
	localparam zx_pkg::mem_mode_e mprofi = zx_pkg::mm_profi1024;
	localparam zx_pkg::mem_mode_e mplus3 = zx_pkg::mm_plus3;
	localparam logic acc_rd = 1'b0;
	localparam logic acc_wr = 1'b1;

	typedef struct {
		string              name;
		zx_pkg::mem_mode_e  mode;
		int                 n_writes;
		logic [15:0]        wr_port [3];
		logic [7:0]         wr_data [3];
		logic [1:0]         quarter;
		logic [13:0]        offset;      // Replaced by a random value in quarter 3
		logic               is_write;
		logic [9:0]         exp_base;    // ram_addr bits 23 to 14
		logic               exp_we;
		logic               exp_scr;
	} step_t;

	// ============================================================
	// DUT and clock
	// ============================================================
	logic                      clk_sys;
	logic                      reset;
	logic                      restart;
	zx_pkg::mem_mode_e         mem_mode_cfg;
	logic [`ZX_ADDR_W-1:0]     addr;
	logic [`ZX_DATA_W-1:0]     data_out;
	logic                      n_mreq;
	logic                      n_iorq;
	logic                      n_rd;
	logic                      n_wr;
	logic                      n_m1;
	logic [`ZX_RAM_ADDR_W-1:0] ram_addr;
	logic                      ram_rd;
	logic                      ram_we;
	logic                      scr_page;

	clk_gen u_clk_gen (
		.restart (restart),
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	zx_memory_map dut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.mem_mode_cfg (mem_mode_cfg),
		.addr         (addr),
		.data_out     (data_out),
		.n_mreq       (n_mreq),
		.n_iorq       (n_iorq),
		.n_rd         (n_rd),
		.n_wr         (n_wr),
		.n_m1         (n_m1),
		.ram_addr     (ram_addr),
		.ram_rd       (ram_rd),
		.ram_we       (ram_we),
		.scr_page     (scr_page)
	);

	step_t       steps [$];
	logic [15:0] pend_port [3];
	logic [7:0]  pend_data [3];
	int          pend_n = 0;
	bit          table_ready = 1'b0;
	integer      seed;
	int          addr_errs = 0;
	int          we_errs = 0;
	int          rd_errs = 0;
	int          scr_errs = 0;
	int          assert_errs;
	int          total_errs;

	// ============================================================
	// Expected address helpers
	// ============================================================
	function automatic logic [9:0] rom_base(input logic [3:0] bank);
		return {3'b000, `ZX_ROM_PREFIX, bank};
	endfunction

	function automatic logic [9:0] page_base(input logic [5:0] page);
		return {4'b0000, page};
	endfunction

	task automatic queue_write(input logic [15:0] port, input logic [7:0] data);
		pend_port[pend_n] = port;
		pend_data[pend_n] = data;
		pend_n++;
	endtask

	task automatic add_step(input string name, input zx_pkg::mem_mode_e mode,
			input logic [1:0] quarter, input logic [13:0] offset, input logic is_write,
			input logic [9:0] exp_base, input logic exp_we, input logic exp_scr);
		step_t st;
		st.name     = name;
		st.mode     = mode;
		st.n_writes = pend_n;
		for (int i = 0; i < 3; i++) begin
			st.wr_port[i] = pend_port[i];
			st.wr_data[i] = pend_data[i];
		end
		st.quarter  = quarter;
		st.offset   = offset;
		st.is_write = is_write;
		st.exp_base = exp_base;
		st.exp_we   = exp_we;
		st.exp_scr  = exp_scr;
		pend_n      = 0;
		steps.push_back(st);
	endtask

	task automatic build_table();
		// 128K paging and ROM select
		queue_write(16'h7FFD, 8'h0B);
		add_step("128_page3_shadow", m128, 2'd3, 14'h0, acc_rd, page_base(6'd3), 1'b0, 1'b1);
		queue_write(16'h7FFD, 8'h10);
		add_step("128_rom3", m128, 2'd0, 14'h0123, acc_rd, rom_base(4'b0111), 1'b0, 1'b0);
		add_step("128_rom_default", m128, 2'd0, 14'h0456, acc_rd, rom_base(4'b0110), 1'b0, 1'b0);
		add_step("128_q1_page5", m128, 2'd1, 14'h1abc, acc_rd, page_base(6'd5), 1'b0, 1'b0);
		add_step("128_q2_page2", m128, 2'd2, 14'h2001, acc_rd, page_base(6'd2), 1'b0, 1'b0);
		// Lock bit and 48K model
		queue_write(16'h7FFD, 8'h21);
		queue_write(16'h7FFD, 8'h0E);
		add_step("128_lock_page", m128, 2'd3, 14'h0, acc_rd, page_base(6'd1), 1'b0, 1'b0);
		queue_write(16'h7FFD, 8'h20);
		queue_write(16'h7FFD, 8'h10);
		add_step("128_lock_rom", m128, 2'd0, 14'h0010, acc_rd, rom_base(4'b0110), 1'b0, 1'b0);
		queue_write(16'h7FFD, 8'h0F);
		add_step("48_no_paging", m48, 2'd3, 14'h0, acc_rd, page_base(6'd0), 1'b0, 1'b0);
		queue_write(16'h7FFD, 8'h10);
		add_step("48_rom", m48, 2'd0, 14'h0100, acc_rd, rom_base(4'b1111), 1'b0, 1'b0);
		// +3 special layouts
		queue_write(16'h1FFD, 8'h03);
		add_step("p3_r1_q0", mplus3, 2'd0, 14'h0011, acc_rd, page_base(6'd4), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h03);
		add_step("p3_r1_q1", mplus3, 2'd1, 14'h0022, acc_rd, page_base(6'd5), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h03);
		add_step("p3_r1_q2", mplus3, 2'd2, 14'h0033, acc_rd, page_base(6'd6), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h03);
		add_step("p3_r1_q3", mplus3, 2'd3, 14'h0, acc_rd, page_base(6'd7), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h05);
		add_step("p3_r2_q0", mplus3, 2'd0, 14'h0044, acc_rd, page_base(6'd4), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h05);
		add_step("p3_r2_q3", mplus3, 2'd3, 14'h0, acc_rd, page_base(6'd3), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h07);
		add_step("p3_r3_q1", mplus3, 2'd1, 14'h0055, acc_rd, page_base(6'd7), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h07);
		add_step("p3_r3_q3", mplus3, 2'd3, 14'h0, acc_rd, page_base(6'd3), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h01);
		add_step("p3_r0_q2", mplus3, 2'd2, 14'h0066, acc_rd, page_base(6'd2), 1'b0, 1'b0);
		queue_write(16'h1FFD, 8'h03);
		add_step("p3_q0_write", mplus3, 2'd0, 14'h0100, acc_wr, page_base(6'd4), 1'b1, 1'b0);
		add_step("p3_rom_default", mplus3, 2'd0, 14'h0077, acc_rd, rom_base(4'b1000), 1'b0, 1'b0);
		// Pentagon and Profi extended pages
		queue_write(16'h7FFD, 8'hC2);
		add_step("pent_ext_page", mpent, 2'd3, 14'h0, acc_rd, page_base(6'd26), 1'b0, 1'b0);
		queue_write(16'h7FFD, 8'h20);
		queue_write(16'h7FFD, 8'h43);
		add_step("pent_bit5_free", mpent, 2'd3, 14'h0, acc_rd, page_base(6'd11), 1'b0, 1'b0);
		queue_write(16'h7FFD, 8'hC0);
		queue_write(16'hEFF7, 8'h04);
		queue_write(16'h7FFD, 8'h05);
		add_step("pent_eff7_hold", mpent, 2'd3, 14'h0, acc_rd, page_base(6'd29), 1'b0, 1'b0);
		queue_write(16'hDFFD, 8'h05);
		queue_write(16'h7FFD, 8'h02);
		add_step("profi_dffd", mprofi, 2'd3, 14'h0, acc_rd, page_base(6'd42), 1'b0, 1'b0);
		// Write protect of the ROM quarter
		add_step("128_q0_write", m128, 2'd0, 14'h1234, acc_wr, rom_base(4'b0110), 1'b0, 1'b0);
		queue_write(16'h7FFD, 8'h10);
		add_step("48_q0_write", m48, 2'd0, 14'h0200, acc_wr, rom_base(4'b1111), 1'b0, 1'b0);
		add_step("128_q1_write", m128, 2'd1, 14'h0777, acc_wr, page_base(6'd5), 1'b1, 1'b0);
		add_step("pent_q3_read", mpent, 2'd3, 14'h0, acc_rd, page_base(6'd0), 1'b0, 1'b0);
		add_step("profi_q2_write", mprofi, 2'd2, 14'h3ffe, acc_wr, page_base(6'd2), 1'b1, 1'b0);
	endtask

	// ============================================================
	// Bus cycles driven on the falling edge
	// ============================================================
	task automatic restart_model(input zx_pkg::mem_mode_e mode);
		mem_mode_cfg = mode;
		restart      = 1'b1;
		@(negedge clk_sys);
		restart = 1'b0;
		io_write(16'h7FFD, 8'h3F);    // Port write while reset is held
		while (reset) begin
			@(negedge clk_sys);
		end
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] data);
		addr     = port;
		data_out = data;
		n_iorq   = 1'b0;
		n_wr     = 1'b0;
		repeat (2) @(negedge clk_sys);
		n_iorq = 1'b1;
		n_wr   = 1'b1;
		@(negedge clk_sys);     // Idle gap between writes
	endtask

	task automatic run_step(input int idx);
		step_t       st;
		logic [13:0] off;
		logic [23:0] exp_addr;
		int          rnd;
		st  = steps[idx];
		off = st.offset;
		if (st.quarter == 2'd3) begin
			rnd = $random(seed);
			off = rnd[13:0];
		end
		exp_addr = {st.exp_base, off};
		restart_model(st.mode);
		for (int i = 0; i < st.n_writes; i++) begin
			io_write(st.wr_port[i], st.wr_data[i]);
		end
		addr   = {st.quarter, off};
		n_mreq = 1'b0;
		n_rd   = st.is_write;
		n_wr   = ~st.is_write;
		@(posedge clk_sys);
		@(negedge clk_sys);
		if (ram_addr !== exp_addr) begin
			$display("mismatch %s ram_addr expected %h actual %h", st.name, exp_addr, ram_addr);
			addr_errs++;
		end
		if (ram_we !== st.exp_we) begin
			$display("mismatch %s ram_we expected %b actual %b", st.name, st.exp_we, ram_we);
			we_errs++;
		end
		if (ram_rd !== ~st.is_write) begin
			$display("mismatch %s ram_rd expected %b actual %b", st.name, ~st.is_write, ram_rd);
			rd_errs++;
		end
		if (scr_page !== st.exp_scr) begin
			$display("mismatch %s scr_page expected %b actual %b", st.name, st.exp_scr, scr_page);
			scr_errs++;
		end
		n_mreq = 1'b1;
		n_rd   = 1'b1;
		n_wr   = 1'b1;
	endtask

	initial begin
		seed         = 32'hb554_72f6;
		restart      = 1'b0;
		mem_mode_cfg = zx_pkg::mm_std128;
		addr         = '0;
		data_out     = '0;
		n_mreq       = 1'b1;
		n_iorq       = 1'b1;
		n_rd         = 1'b1;
		n_wr         = 1'b1;
		n_m1         = 1'b1;    // No M1 cycles in these tests
		build_table();
		table_ready = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < steps.size(); i++) begin
			run_step(i);
		end
		assert_errs = dut.u_asserts.assert_fails;
		total_errs  = addr_errs + we_errs + rd_errs + scr_errs + assert_errs;
		$display("errors: ram_addr %0d, ram_we %0d, ram_rd %0d, scr_page %0d, %s %0d, total %0d",
			addr_errs, we_errs, rd_errs, scr_errs, "assertions", assert_errs, total_errs);
		if (total_errs == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Watchdog budget of 40 clocks per row with a factor of two
	initial begin
		wait (table_ready);
		repeat (2 * steps.size() * 40) @(posedge clk_sys);
		$display("timeout: the run did not finish within %0d clock cycles",
			2 * steps.size() * 40);
		$display("tests failed");
		$finish;
	end

endmodule

/* list.f */
+incdir+hdl
hdl/zx_pkg.sv
hdl/io_cycle_decode.sv
hdl/page_regs.sv
hdl/ram_addr_map.sv
hdl/zx_memory_map.sv
dv/clk_gen.sv
dv/zx_memory_map_asserts.sv
dv/zx_memory_map_tb.sv
